// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dla
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := Result: PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) $(SIM_ARGS))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/dla_asserts.sv
`timescale 1ns/1ps

module dla_asserts import dla_pkg::*; #(
   parameter int ARRAY_DIM = 4
) (
   input logic     clk,
   input logic     rst_i,
   input logic     psel_i,
   input logic     penable_i,
   input logic     pready_i,
   input logic     start_i,
   input sram_rd_t wgt_rd_i,
   input sram_rd_t xin_rd_i,
   input sram_wr_t res_wr_i
);

   localparam int WIN_W = $clog2(ARRAY_DIM + 1);

   int               fail_cnt = 0;
   logic             started_q;
   logic [WIN_W-1:0] win_q;
   logic             have_wr_q;
   addr_t            last_addr_q;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         started_q <= 1'b0;
         win_q     <= '0;
         have_wr_q <= 1'b0;
      end else begin
         if (start_i) begin
            started_q <= 1'b1;
         end
         // Weight read window opens the cycle after start
         if (start_i) begin
            win_q <= WIN_W'(ARRAY_DIM);
         end else if (win_q != '0) begin
            win_q <= win_q - 1'b1;
         end
         if (start_i) begin
            have_wr_q <= 1'b0;
         end else if (res_wr_i.en) begin
            have_wr_q   <= 1'b1;
            last_addr_q <= res_wr_i.addr;
         end
      end
   end

   pready_zero_wait: assert property (@(posedge clk) pready_i == (psel_i && penable_i))
      else begin
         $error("pready does not follow the APB access phase");
         fail_cnt++;
      end

   no_early_sram: assert property (@(posedge clk) disable iff (rst_i)
      !started_q |-> !(wgt_rd_i.en || xin_rd_i.en || res_wr_i.en))
      else begin
         $error("SRAM access before the first start");
         fail_cnt++;
      end

   wgt_read_window: assert property (@(posedge clk) disable iff (rst_i)
      wgt_rd_i.en == (win_q != '0))
      else begin
         $error("weight read outside the load window");
         fail_cnt++;
      end

   res_addr_step: assert property (@(posedge clk) disable iff (rst_i)
      (res_wr_i.en && have_wr_q) |-> res_wr_i.addr == last_addr_q + addr_t'(1))
      else begin
         $error("result address does not step by one");
         fail_cnt++;
      end

endmodule

bind dla_top dla_asserts #(.ARRAY_DIM(ARRAY_DIM)) u_asserts (
   .clk       (clk),
   .rst_i     (rst_i),
   .psel_i    (psel_i),
   .penable_i (penable_i),
   .pready_i  (pready_o),
   .start_i   (start),
   .wgt_rd_i  (wgt_rd_o),
   .xin_rd_i  (xin_rd_o),
   .res_wr_i  (res_wr_o)
);

// File: dv/tb_dla.sv
`timescale 1ns/1ps

module tb_dla import dla_pkg::*;;

   localparam int ARRAY_DIM = 4;
   localparam int WORD_W    = ARRAY_DIM * 8;
   // Budget per test is its vector count plus fixed overhead
   localparam int TIMEOUT_CYC = 20 * ((1 + 12 + 6 + 8) + 6 * (4 * ARRAY_DIM + 20));

   logic        clk = 1'b0;
   logic        rst_i;
   logic        psel_i;
   logic        penable_i;
   logic        pwrite_i;
   logic [15:0] paddr_i;
   logic [31:0] pwdata_i;
   logic [31:0] prdata;
   logic        pready;
   sram_rd_t    wgt_rd;
   data_t       wgt_rdata [ARRAY_DIM];
   sram_rd_t    xin_rd;
   data_t       xin_rdata [ARRAY_DIM];
   sram_wr_t    res_wr;
   acc_t        res_wdata [ARRAY_DIM];

   logic [WORD_W-1:0]        wgt_mem [256];
   logic [WORD_W-1:0]        xin_mem [256];
   addr_t                    res_addr_q [$];
   logic [ARRAY_DIM*32-1:0]  res_data_q [$];
   int                       xin_rd_count = 0;
   int                       errors = 0;
   int                       tests_run = 0;
   int                       tests_failed = 0;
   int                       cycles = 0;
   logic [15:0]              lfsr_q = 16'd36998;

   dla_top #(.ARRAY_DIM(ARRAY_DIM)) uut (
      .clk         (clk),
      .rst_i       (rst_i),
      .psel_i      (psel_i),
      .penable_i   (penable_i),
      .pwrite_i    (pwrite_i),
      .paddr_i     (paddr_i),
      .pwdata_i    (pwdata_i),
      .prdata_o    (prdata),
      .pready_o    (pready),
      .wgt_rd_o    (wgt_rd),
      .wgt_rdata_i (wgt_rdata),
      .xin_rd_o    (xin_rd),
      .xin_rdata_i (xin_rdata),
      .res_wr_o    (res_wr),
      .res_wdata_o (res_wdata)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYC) begin
         $display("timeout after %0d cycles, the engine never went idle", cycles);
         $display("Result: FAILED");
         $finish;
      end
   end

   // SRAM models return read data one cycle after the enable
   always @(posedge clk) begin : sram_model
      sram_rd_t                wq;
      sram_rd_t                xq;
      logic [ARRAY_DIM*32-1:0] wd;
      wq = wgt_rd;
      xq = xin_rd;
      if (res_wr.en) begin
         for (int c = 0; c < ARRAY_DIM; c++) begin
            wd[32*c +: 32] = res_wdata[c];
         end
         res_addr_q.push_back(res_wr.addr);
         res_data_q.push_back(wd);
      end
      if (xq.en) begin
         xin_rd_count++;
      end
      #1;
      for (int i = 0; i < ARRAY_DIM; i++) begin
         if (wq.en) begin
            wgt_rdata[i] = wgt_mem[wq.addr[7:0]][8*i +: 8];
         end
         if (xq.en) begin
            xin_rdata[i] = xin_mem[xq.addr[7:0]][8*i +: 8];
         end
      end
   end

   // Taps 16, 14, 13, 11
   function automatic logic lfsr_bit();
      logic fb;
      fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      return fb;
   endfunction

   function automatic logic [7:0] random_byte();
      logic [7:0] b;
      for (int i = 0; i < 8; i++) begin
         b[i] = lfsr_bit();
      end
      return b;
   endfunction

   function automatic acc_t expected_elem(input int wb, input int xb, input int k, input int c);
      acc_t  sum;
      data_t x;
      data_t w;
      sum = '0;
      for (int r = 0; r < ARRAY_DIM; r++) begin
         x   = xin_mem[(xb + k) & 255][8*r +: 8];
         w   = wgt_mem[(wb + r) & 255][8*c +: 8];
         sum = sum + acc_t'(x) * acc_t'(w);
      end
      return sum;
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
      assert (got === exp) else begin
         errors++;
         $display("mismatch %s: expected %h, got %h", name, exp, got);
      end
   endtask

   task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
      @(posedge clk);
      #1;
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = 1'b1;
      paddr_i   = addr;
      pwdata_i  = data;
      @(posedge clk);
      #1;
      penable_i = 1'b1;
      @(posedge clk);
      #1;
      psel_i    = 1'b0;
      penable_i = 1'b0;
   endtask

   task automatic read_reg(input logic [15:0] addr, output logic [31:0] data);
      @(posedge clk);
      #1;
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
      paddr_i   = addr;
      @(posedge clk);
      #1;
      penable_i = 1'b1;
      #1;
      data = prdata;
      @(posedge clk);
      #1;
      psel_i    = 1'b0;
      penable_i = 1'b0;
   endtask

   task automatic run_job(input int wb, input int xb, input int ob, input int n,
                          input bit double_start, output int first_wr, output int reads);
      int          first_rd;
      logic [31:0] st;
      bit          saw_busy;
      first_wr = res_addr_q.size();
      first_rd = xin_rd_count;
      saw_busy = 1'b0;
      write_reg(REG_WGT_BASE, wb);
      write_reg(REG_XIN_BASE, xb);
      write_reg(REG_OUT_BASE, ob);
      write_reg(REG_VEC_COUNT, n);
      write_reg(REG_CTRL, 32'd1);
      if (double_start) begin
         // Second start lands while the vectors stream
         repeat (2 * ARRAY_DIM) @(posedge clk);
         write_reg(REG_CTRL, 32'd1);
      end
      do begin
         read_reg(REG_STATUS, st);
         if (st[0]) begin
            saw_busy = 1'b1;
         end
      end while (st[0]);
      assert (saw_busy) else begin
         errors++;
         $display("busy never read high after the start write");
      end
      reads = xin_rd_count - first_rd;
   endtask

   task automatic check_job(input int wb, input int xb, input int ob, input int n, input int first);
      int got;
      got = res_addr_q.size() - first;
      check_value("result write count", n, got);
      for (int k = 0; k < got && k < n; k++) begin
         check_value($sformatf("res_wr_o.addr vec %0d", k), 32'(addr_t'(ob + k)),
                     32'(res_addr_q[first + k]));
         for (int c = 0; c < ARRAY_DIM; c++) begin
            check_value($sformatf("res_wdata_o[%0d] vec %0d", c, k), expected_elem(wb, xb, k, c),
                        res_data_q[first + k][32*c +: 32]);
         end
      end
   endtask

   task automatic report_test(input string name, input int err_before);
      tests_run++;
      if (errors > err_before) begin
         tests_failed++;
         $display("test %0d %s: FAIL, %0d errors", tests_run, name, errors - err_before);
      end else begin
         $display("test %0d %s: ok", tests_run, name);
      end
   endtask

   initial begin
      int          first;
      int          reads;
      int          e0;
      int          asrt;
      logic [31:0] v;
      rst_i     = 1'b1;
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
      paddr_i   = '0;
      pwdata_i  = '0;
      for (int i = 0; i < ARRAY_DIM; i++) begin
         wgt_rdata[i] = '0;
         xin_rdata[i] = '0;
      end
      for (int a = 0; a < 256; a++) begin
         for (int b = 0; b < ARRAY_DIM; b++) begin
            wgt_mem[a][8*b +: 8] = random_byte();
            xin_mem[a][8*b +: 8] = random_byte();
         end
      end
      // Extreme operands lead the first jobs
      xin_mem[8'h10] = {ARRAY_DIM{8'h80}};
      xin_mem[8'h20] = {ARRAY_DIM{8'h80}};
      xin_mem[8'h21] = {ARRAY_DIM{8'h7F}};
      repeat (4) @(posedge clk);
      #1;
      rst_i = 1'b0;

      e0 = errors;
      for (int i = 0; i < 6; i++) begin
         read_reg(16'(4 * i), v);
         check_value($sformatf("prdata_o reg %h after reset", 4 * i), 32'd0, v);
      end
      write_reg(REG_WGT_BASE, 32'h1234);
      write_reg(REG_XIN_BASE, 32'hBEEF);
      write_reg(REG_OUT_BASE, 32'h00C3);
      write_reg(REG_VEC_COUNT, 32'h0055);
      read_reg(REG_WGT_BASE, v);
      check_value("prdata_o wgt_base", 32'h1234, v);
      read_reg(REG_XIN_BASE, v);
      check_value("prdata_o xin_base", 32'hBEEF, v);
      read_reg(REG_OUT_BASE, v);
      check_value("prdata_o out_base", 32'h00C3, v);
      read_reg(REG_VEC_COUNT, v);
      check_value("prdata_o vec_count", 32'h0055, v);
      read_reg(REG_STATUS, v);
      check_value("prdata_o status", 32'd0, v);
      report_test("register access", e0);

      e0 = errors;
      run_job(8'h00, 8'h10, 8'h40, 1, 1'b0, first, reads);
      check_job(8'h00, 8'h10, 8'h40, 1, first);
      report_test("single vector", e0);

      e0 = errors;
      run_job(8'h00, 8'h20, 8'h60, 12, 1'b0, first, reads);
      check_job(8'h00, 8'h20, 8'h60, 12, first);
      check_value("activation reads", 32'd12, reads);
      report_test("twelve vectors", e0);

      e0 = errors;
      run_job(8'h08, 8'h30, 8'h80, 6, 1'b0, first, reads);
      check_job(8'h08, 8'h30, 8'h80, 6, first);
      report_test("new weights and bases", e0);

      e0 = errors;
      run_job(8'h04, 8'h40, 8'hA0, 8, 1'b1, first, reads);
      // Quiet period to catch a stray second job
      repeat (4 * ARRAY_DIM) @(posedge clk);
      check_job(8'h04, 8'h40, 8'hA0, 8, first);
      check_value("activation reads", 32'd8, reads);
      report_test("start while busy", e0);

      e0 = errors;
      run_job(8'h00, 8'h50, 8'hC0, 0, 1'b0, first, reads);
      check_job(8'h00, 8'h50, 8'hC0, 0, first);
      check_value("activation reads", 32'd0, reads);
      report_test("empty job", e0);

      asrt = uut.u_asserts.fail_cnt;
      $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
               tests_run, tests_failed, errors, asrt);
      if (errors == 0 && tests_failed == 0 && asrt == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// File: source/dla_apb_regs.sv
`timescale 1ns/1ps

module dla_apb_regs import dla_pkg::*; (
   input  logic        clk,
   input  logic        rst_i,
   input  logic        psel_i,
   input  logic        penable_i,
   input  logic        pwrite_i,
   input  logic [15:0] paddr_i,
   input  logic [31:0] pwdata_i,
   output logic [31:0] prdata_o,
   output logic        pready_o,
   input  logic        busy_clr_i,
   output logic        start_o,
   output cfg_t        cfg_o
);

   logic access;
   logic wr_en;
   logic start_req;
   logic start_q;
   logic busy_q;
   cfg_t cfg_q;

   // Zero wait states
   assign access   = psel_i & penable_i;
   assign wr_en    = access & pwrite_i;
   assign pready_o = access;

   assign start_req = wr_en && (paddr_i == REG_CTRL) && pwdata_i[0] && !busy_q;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         cfg_q <= '0;
      end else if (wr_en) begin
         case (paddr_i)
            REG_WGT_BASE:  cfg_q.wgt_base  <= pwdata_i[SRAM_ADDR_W-1:0];
            REG_XIN_BASE:  cfg_q.xin_base  <= pwdata_i[SRAM_ADDR_W-1:0];
            REG_OUT_BASE:  cfg_q.out_base  <= pwdata_i[SRAM_ADDR_W-1:0];
            REG_VEC_COUNT: cfg_q.vec_count <= pwdata_i[SRAM_ADDR_W-1:0];
            default: ;
         endcase
      end
   end

   // Busy rises together with the start pulse
   always_ff @(posedge clk) begin
      if (rst_i) begin
         start_q <= 1'b0;
         busy_q  <= 1'b0;
      end else begin
         start_q <= start_req;
         if (start_req) begin
            busy_q <= 1'b1;
         end else if (busy_clr_i) begin
            busy_q <= 1'b0;
         end
      end
   end

   always_comb begin
      prdata_o = '0;
      if (psel_i && !pwrite_i) begin
         case (paddr_i)
            REG_STATUS:    prdata_o = {31'd0, busy_q};
            REG_WGT_BASE:  prdata_o = 32'(cfg_q.wgt_base);
            REG_XIN_BASE:  prdata_o = 32'(cfg_q.xin_base);
            REG_OUT_BASE:  prdata_o = 32'(cfg_q.out_base);
            REG_VEC_COUNT: prdata_o = 32'(cfg_q.vec_count);
            default:       prdata_o = '0;
         endcase
      end
   end

   assign start_o = start_q;
   assign cfg_o   = cfg_q;

endmodule

// File: source/dla_pe_array.sv
`timescale 1ns/1ps

module dla_pe_array import dla_pkg::*; #(
   parameter int ARRAY_DIM = 4
) (
   input  logic                         clk,
   input  logic                         rst_i,
   input  logic                         wgt_load_i,
   input  logic [$clog2(ARRAY_DIM)-1:0] wgt_row_i,
   input  data_t                        wgt_data_i [ARRAY_DIM],
   input  logic [ARRAY_DIM-1:0]         row_valid_i,
   input  data_t                        row_data_i [ARRAY_DIM],
   output logic [ARRAY_DIM-1:0]         col_valid_o,
   output acc_t                         col_sum_o [ARRAY_DIM]
);

   localparam int ROW_W = $clog2(ARRAY_DIM);

   // Registered cell outputs, indexed [row][col]
   data_t act_w [ARRAY_DIM][ARRAY_DIM];
   logic  vld_w [ARRAY_DIM][ARRAY_DIM];
   acc_t  sum_w [ARRAY_DIM][ARRAY_DIM];

   for (genvar r = 0; r < ARRAY_DIM; r++) begin : g_row
      for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_col
         data_t              act_in;
         logic               vld_in;
         acc_t               psum_in;
         data_t              w_q;
         data_t              act_q;
         logic               vld_q;
         acc_t               sum_q;
         logic signed [15:0] prod;

         if (c == 0) begin : g_left
            assign act_in = row_data_i[r];
            assign vld_in = row_valid_i[r];
         end else begin : g_inner
            assign act_in = act_w[r][c-1];
            assign vld_in = vld_w[r][c-1];
         end

         if (r == 0) begin : g_top
            assign psum_in = '0;
         end else begin : g_below
            assign psum_in = sum_w[r-1][c];
         end

         assign prod = act_in * w_q;

         always_ff @(posedge clk) begin
            if (wgt_load_i && (wgt_row_i == ROW_W'(r))) begin
               w_q <= wgt_data_i[c];
            end
         end

         always_ff @(posedge clk) begin
            if (rst_i) begin
               vld_q <= 1'b0;
            end else begin
               vld_q <= vld_in;
            end
         end

         // Activation moves right, partial sum moves down
         always_ff @(posedge clk) begin
            act_q <= act_in;
            sum_q <= vld_in ? psum_in + acc_t'(prod) : psum_in;
         end

         assign act_w[r][c] = act_q;
         assign vld_w[r][c] = vld_q;
         assign sum_w[r][c] = sum_q;
      end
   end

   // Bottom row, column c lags column 0 by c cycles
   always_comb begin
      for (int c = 0; c < ARRAY_DIM; c++) begin
         col_valid_o[c] = vld_w[ARRAY_DIM-1][c];
         col_sum_o[c]   = sum_w[ARRAY_DIM-1][c];
      end
   end

endmodule

// File: source/dla_pkg.sv
package dla_pkg;

   localparam int SRAM_ADDR_W = 16;

   typedef logic signed [7:0]      data_t;
   typedef logic signed [31:0]     acc_t;
   typedef logic [SRAM_ADDR_W-1:0] addr_t;

   // APB register byte offsets
   typedef enum logic [15:0] {
      REG_CTRL      = 16'h0000,
      REG_STATUS    = 16'h0004,
      REG_WGT_BASE  = 16'h0008,
      REG_XIN_BASE  = 16'h000C,
      REG_OUT_BASE  = 16'h0010,
      REG_VEC_COUNT = 16'h0014
   } reg_addr_e;

   typedef struct packed {
      addr_t wgt_base;
      addr_t xin_base;
      addr_t out_base;
      addr_t vec_count;
   } cfg_t;

   typedef struct packed {
      logic  en;
      addr_t addr;
   } sram_rd_t;

   typedef struct packed {
      logic  en;
      addr_t addr;
   } sram_wr_t;

   typedef enum logic [1:0] {
      LD_IDLE,
      LD_READ,
      LD_DRAIN
   } ld_state_e;

endpackage

// File: source/dla_result_writer.sv
`timescale 1ns/1ps

module dla_result_writer import dla_pkg::*; #(
   parameter int ARRAY_DIM = 4
) (
   input  logic                 clk,
   input  logic                 rst_i,
   input  logic                 start_i,
   input  cfg_t                 cfg_i,
   input  logic [ARRAY_DIM-1:0] col_valid_i,
   input  acc_t                 col_sum_i [ARRAY_DIM],
   output sram_wr_t             res_wr_o,
   output acc_t                 res_wdata_o [ARRAY_DIM],
   input  logic                 stream_last_i,
   output logic                 done_o
);

   wire [ARRAY_DIM-1:0] al_vld;
   acc_t                al_sum [ARRAY_DIM];
   logic                wr_en;
   addr_t               wr_cnt_q;
   logic                armed_q;

   // Column c waits ARRAY_DIM-1-c cycles so the word lines up
   for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_col
      if (c == ARRAY_DIM - 1) begin : g_direct
         assign al_vld[c] = col_valid_i[c];
         assign al_sum[c] = col_sum_i[c];
      end else begin : g_delay
         localparam int DEPTH = ARRAY_DIM - 1 - c;
         logic [DEPTH-1:0] v_sr;
         acc_t             s_sr [DEPTH];

         always_ff @(posedge clk) begin
            if (rst_i) begin
               v_sr <= '0;
            end else begin
               v_sr <= DEPTH'({v_sr, col_valid_i[c]});
            end
         end

         always_ff @(posedge clk) begin
            s_sr[0] <= col_sum_i[c];
            for (int i = 1; i < DEPTH; i++) begin
               s_sr[i] <= s_sr[i-1];
            end
         end

         assign al_vld[c] = v_sr[DEPTH-1];
         assign al_sum[c] = s_sr[DEPTH-1];
      end
   end

   assign wr_en         = &al_vld;
   assign res_wr_o.en   = wr_en;
   assign res_wr_o.addr = cfg_i.out_base + wr_cnt_q;
   assign res_wdata_o   = al_sum;

   // Empty once every issued vector has been written back
   assign done_o = armed_q && (wr_cnt_q == cfg_i.vec_count);

   always_ff @(posedge clk) begin
      if (rst_i) begin
         wr_cnt_q <= '0;
         armed_q  <= 1'b0;
      end else begin
         if (start_i) begin
            wr_cnt_q <= '0;
         end else if (wr_en) begin
            wr_cnt_q <= wr_cnt_q + addr_t'(1);
         end
         if (start_i || done_o) begin
            armed_q <= 1'b0;
         end else if (stream_last_i) begin
            armed_q <= 1'b1;
         end
      end
   end

endmodule

// File: source/dla_top.sv
`timescale 1ns/1ps

module dla_top import dla_pkg::*; #(
   parameter int ARRAY_DIM = 4
) (
   input  logic        clk,
   input  logic        rst_i,
   input  logic        psel_i,
   input  logic        penable_i,
   input  logic        pwrite_i,
   input  logic [15:0] paddr_i,
   input  logic [31:0] pwdata_i,
   output logic [31:0] prdata_o,
   output logic        pready_o,
   output sram_rd_t    wgt_rd_o,
   input  data_t       wgt_rdata_i [ARRAY_DIM],
   output sram_rd_t    xin_rd_o,
   input  data_t       xin_rdata_i [ARRAY_DIM],
   output sram_wr_t    res_wr_o,
   output acc_t        res_wdata_o [ARRAY_DIM]
);

   cfg_t                         cfg;
   logic                         start;
   logic                         wr_done;
   logic                         wgt_load;
   logic [$clog2(ARRAY_DIM)-1:0] wgt_row;
   data_t                        wgt_data [ARRAY_DIM];
   logic                         ld_done;
   logic [ARRAY_DIM-1:0]         row_valid;
   data_t                        row_data [ARRAY_DIM];
   logic                         stream_last;
   logic [ARRAY_DIM-1:0]         col_valid;
   acc_t                         col_sum [ARRAY_DIM];

   dla_apb_regs u_regs (
      .clk        (clk),
      .rst_i      (rst_i),
      .psel_i     (psel_i),
      .penable_i  (penable_i),
      .pwrite_i   (pwrite_i),
      .paddr_i    (paddr_i),
      .pwdata_i   (pwdata_i),
      .prdata_o   (prdata_o),
      .pready_o   (pready_o),
      .busy_clr_i (wr_done),
      .start_o    (start),
      .cfg_o      (cfg)
   );

   dla_wgt_loader #(.ARRAY_DIM(ARRAY_DIM)) u_wgt_loader (
      .clk         (clk),
      .rst_i       (rst_i),
      .start_i     (start),
      .cfg_i       (cfg),
      .wgt_rd_o    (wgt_rd_o),
      .wgt_rdata_i (wgt_rdata_i),
      .wgt_load_o  (wgt_load),
      .wgt_row_o   (wgt_row),
      .wgt_data_o  (wgt_data),
      .done_o      (ld_done)
   );

   // Activations follow once all weights sit in the array
   dla_xin_streamer #(.ARRAY_DIM(ARRAY_DIM)) u_xin_streamer (
      .clk         (clk),
      .rst_i       (rst_i),
      .start_i     (ld_done),
      .cfg_i       (cfg),
      .xin_rd_o    (xin_rd_o),
      .xin_rdata_i (xin_rdata_i),
      .row_valid_o (row_valid),
      .row_data_o  (row_data),
      .last_o      (stream_last)
   );

   dla_pe_array #(.ARRAY_DIM(ARRAY_DIM)) u_pe_array (
      .clk         (clk),
      .rst_i       (rst_i),
      .wgt_load_i  (wgt_load),
      .wgt_row_i   (wgt_row),
      .wgt_data_i  (wgt_data),
      .row_valid_i (row_valid),
      .row_data_i  (row_data),
      .col_valid_o (col_valid),
      .col_sum_o   (col_sum)
   );

   dla_result_writer #(.ARRAY_DIM(ARRAY_DIM)) u_result_writer (
      .clk           (clk),
      .rst_i         (rst_i),
      .start_i       (start),
      .cfg_i         (cfg),
      .col_valid_i   (col_valid),
      .col_sum_i     (col_sum),
      .res_wr_o      (res_wr_o),
      .res_wdata_o   (res_wdata_o),
      .stream_last_i (stream_last),
      .done_o        (wr_done)
   );

endmodule

// File: source/dla_wgt_loader.sv
`timescale 1ns/1ps

module dla_wgt_loader import dla_pkg::*; #(
   parameter int ARRAY_DIM = 4
) (
   input  logic                         clk,
   input  logic                         rst_i,
   input  logic                         start_i,
   input  cfg_t                         cfg_i,
   output sram_rd_t                     wgt_rd_o,
   input  data_t                        wgt_rdata_i [ARRAY_DIM],
   output logic                         wgt_load_o,
   output logic [$clog2(ARRAY_DIM)-1:0] wgt_row_o,
   output data_t                        wgt_data_o [ARRAY_DIM],
   output logic                         done_o
);

   localparam int ROW_W = $clog2(ARRAY_DIM);

   ld_state_e        state_q;
   logic [ROW_W-1:0] row_q;
   logic             load_q;
   logic [ROW_W-1:0] load_row_q;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q <= LD_IDLE;
         row_q   <= '0;
      end else begin
         case (state_q)
            LD_IDLE: begin
               if (start_i) begin
                  state_q <= LD_READ;
                  row_q   <= '0;
               end
            end
            LD_READ: begin
               row_q <= row_q + 1'b1;
               if (row_q == ROW_W'(ARRAY_DIM - 1)) begin
                  state_q <= LD_DRAIN;
               end
            end
            LD_DRAIN: state_q <= LD_IDLE;
            default:  state_q <= LD_IDLE;
         endcase
      end
   end

   // Row data returns one cycle after its read
   always_ff @(posedge clk) begin
      if (rst_i) begin
         load_q <= 1'b0;
      end else begin
         load_q <= (state_q == LD_READ);
      end
   end

   always_ff @(posedge clk) begin
      load_row_q <= row_q;
   end

   assign wgt_rd_o.en   = (state_q == LD_READ);
   assign wgt_rd_o.addr = cfg_i.wgt_base + addr_t'(row_q);

   assign wgt_load_o = load_q;
   assign wgt_row_o  = load_row_q;
   assign wgt_data_o = wgt_rdata_i;
   assign done_o     = (state_q == LD_DRAIN);

endmodule

// File: source/dla_xin_streamer.sv
`timescale 1ns/1ps

module dla_xin_streamer import dla_pkg::*; #(
   parameter int ARRAY_DIM = 4
) (
   input  logic                 clk,
   input  logic                 rst_i,
   input  logic                 start_i,
   input  cfg_t                 cfg_i,
   output sram_rd_t             xin_rd_o,
   input  data_t                xin_rdata_i [ARRAY_DIM],
   output logic [ARRAY_DIM-1:0] row_valid_o,
   output data_t                row_data_o [ARRAY_DIM],
   output logic                 last_o
);

   logic                 active_q;
   addr_t                cnt_q;
   addr_t                last_idx;
   logic                 last_rd;
   logic [ARRAY_DIM-1:0] vld_sr;

   assign last_idx = cfg_i.vec_count - addr_t'(1);
   assign last_rd  = active_q && (cnt_q == last_idx);

   always_ff @(posedge clk) begin
      if (rst_i) begin
         active_q <= 1'b0;
         cnt_q    <= '0;
      end else if (start_i) begin
         active_q <= (cfg_i.vec_count != '0);
         cnt_q    <= '0;
      end else if (active_q) begin
         cnt_q <= cnt_q + addr_t'(1);
         if (last_rd) begin
            active_q <= 1'b0;
         end
      end
   end

   assign xin_rd_o.en   = active_q;
   assign xin_rd_o.addr = cfg_i.xin_base + cnt_q;

   // An empty job finishes right away
   assign last_o = last_rd || (start_i && (cfg_i.vec_count == '0));

   // Bit r is the read strobe delayed by r+1 cycles
   always_ff @(posedge clk) begin
      if (rst_i) begin
         vld_sr <= '0;
      end else begin
         vld_sr <= ARRAY_DIM'({vld_sr, active_q});
      end
   end

   assign row_valid_o = vld_sr;

   // Row r waits r extra cycles to meet the wavefront
   for (genvar r = 0; r < ARRAY_DIM; r++) begin : g_skew
      if (r == 0) begin : g_direct
         assign row_data_o[r] = xin_rdata_i[r];
      end else begin : g_delay
         data_t d_sr [r];

         always_ff @(posedge clk) begin
            d_sr[0] <= xin_rdata_i[r];
            for (int i = 1; i < r; i++) begin
               d_sr[i] <= d_sr[i-1];
            end
         end

         assign row_data_o[r] = d_sr[r-1];
      end
   end

endmodule

// File: tb.f
source/dla_pkg.sv
source/dla_apb_regs.sv
source/dla_wgt_loader.sv
source/dla_xin_streamer.sv
source/dla_pe_array.sv
source/dla_result_writer.sv
source/dla_top.sv
dv/dla_asserts.sv
dv/tb_dla.sv
